/* logic/mmu_params.svh */
/*
 * Sv32 data MMU constants.
 *  - mstatus bit positions for MPRV, MPP, SUM and MXR
 *  - PTE permission and valid bit positions
 *  - page shift, PTE PPN shift and satp mode bit
 *  - physical address returned on a page fault
 */
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// mstatus fields used for data translation.
`define MSTATUS_MPP_LSB    11  // MPP is two bits wide.
`define MSTATUS_MPRV_BIT   17  // Loads/stores use MPP.
`define MSTATUS_SUM_BIT    18  // S-mode may touch U pages.
`define MSTATUS_MXR_BIT    19  // Execute-only made readable.

// PTE flag bits.
`define PTE_V_BIT          0   // Valid.
`define PTE_R_BIT          1   // Readable.
`define PTE_W_BIT          2   // Writable.
`define PTE_X_BIT          3   // Executable.
`define PTE_U_BIT          4   // User accessible.

// Address geometry.
`define SV32_PAGE_SHIFT    12  // 4 KiB pages.
`define SV32_PTE_PPN_SHIFT 10  // PPN starts above the flags.
`define SATP_MODE_BIT      31  // 1 selects Sv32.

`define FAULT_PADDR        34'h3_ffff_ffff  // All ones on a fault.

`endif

/* logic/mmu_pkg.sv */
/*
 * Shared types of the Sv32 data MMU.
 *  - priv_mode_t   privilege levels
 *  - xlate_state_t translator FSM states
 *  - walk_state_t  page walker FSM states
 */
package mmu_pkg;

  // Encodings follow the mstatus.MPP field.
  typedef enum logic [1:0] {
    PRIV_USER       = 2'd0,  // U-mode.
    PRIV_SUPERVISOR = 2'd1,  // S-mode.
    PRIV_MACHINE    = 2'd3   // M-mode, never translated.
  } priv_mode_t;

  // Translator waits in IDLE for requests and walk results.
  typedef enum logic {
    XLATE_IDLE  = 1'b0,  // Bypass or walk in flight.
    XLATE_CHECK = 1'b1   // Permission check on leaf PTE.
  } xlate_state_t;

  // One state per walk level plus a result cycle.
  typedef enum logic [1:0] {
    WALK_IDLE = 2'd0,  // Waiting for walk_valid.
    WALK_L1   = 2'd1,  // Level-1 PTE read.
    WALK_L0   = 2'd2,  // Level-0 PTE read.
    WALK_DONE = 2'd3   // walk_ready pulse.
  } walk_state_t;

endpackage

/* logic/sv32_translate_data.sv */
/*
 * Data-side Sv32 translator.
 *  - effective privilege from MPRV/MPP
 *  - machine-mode and bare-mode bypass
 *  - walk request handshake to the page walker
 *  - MXR, reserved encoding, SUM and U/R/W permission checks
 */
`timescale 1ns/10ps
`include "mmu_params.svh"

module sv32_translate_data (
  input  logic                clk,
  input  logic                resetn,
  input  logic [31:0]         address,           // Virtual address.
  input  logic                is_write,
  input  mmu_pkg::priv_mode_t privilege_mode,
  input  logic [31:0]         satp,
  input  logic [31:0]         mstatus,
  input  logic                valid,
  output logic [33:0]         physical_address,
  output logic                page_fault,
  output logic                ready,             // One-cycle pulse.
  output logic                walk_valid,
  output logic [31:0]         walk_vaddr,
  output logic [31:0]         walk_satp,
  input  logic                walk_ready,
  input  logic [31:0]         walk_pte,          // Leaf, superpage already merged.
  input  logic                walk_fault
);

  mmu_pkg::xlate_state_t state;
  mmu_pkg::xlate_state_t state_next;
  mmu_pkg::priv_mode_t   eff_priv;

  logic        start;         // First cycle of a new request.
  logic        bypass;        // No translation needed.
  logic [31:0] pte_q;         // Captured leaf PTE.
  logic        walk_fault_q;  // Captured walker fault.
  logic [31:0] pte_eff;       // PTE after MXR.
  logic        perm_fault;
  logic        fault_any;
  logic [21:0] ppn;

  // MPRV makes loads and stores run at MPP.
  always_comb begin
    if (mstatus[`MSTATUS_MPRV_BIT]) begin
      eff_priv = mmu_pkg::priv_mode_t'(mstatus[`MSTATUS_MPP_LSB +: 2]);
    end else begin
      eff_priv = privilege_mode;
    end
  end

  assign bypass = (eff_priv == mmu_pkg::PRIV_MACHINE) || !satp[`SATP_MODE_BIT];

  // A request still high during its ready pulse is not a new one.
  assign start = (state == mmu_pkg::XLATE_IDLE) && valid && !ready;

  // Held until walk_ready, requester keeps inputs stable.
  assign walk_valid = start && !bypass;
  assign walk_vaddr = address;
  assign walk_satp  = satp;

  always_comb begin
    state_next = state;
    case (state)
      mmu_pkg::XLATE_IDLE: begin
        if (walk_valid && walk_ready) begin
          state_next = mmu_pkg::XLATE_CHECK;  // Leaf PTE arrived.
        end
      end
      mmu_pkg::XLATE_CHECK: state_next = mmu_pkg::XLATE_IDLE;
      default:              state_next = mmu_pkg::XLATE_IDLE;
    endcase
  end

  // MXR lets an execute-only page be read.
  always_comb begin
    pte_eff = pte_q;
    if (mstatus[`MSTATUS_MXR_BIT] && pte_q[`PTE_X_BIT]) begin
      pte_eff[`PTE_R_BIT] = 1'b1;
    end
  end

  always_comb begin
    perm_fault = 1'b0;
    if (pte_q[`PTE_W_BIT] && !pte_q[`PTE_R_BIT]) begin
      perm_fault = 1'b1;  // Reserved W without R before MXR.
    end else if (eff_priv == mmu_pkg::PRIV_SUPERVISOR) begin
      if (pte_eff[`PTE_U_BIT] && !mstatus[`MSTATUS_SUM_BIT]) begin
        perm_fault = 1'b1;  // U page without SUM.
      end else if (is_write) begin
        perm_fault = !pte_eff[`PTE_W_BIT];
      end else begin
        perm_fault = !pte_eff[`PTE_R_BIT];
      end
    end else begin
      // User mode needs U plus the access right.
      if (is_write) begin
        perm_fault = !(pte_eff[`PTE_U_BIT] && pte_eff[`PTE_W_BIT]);
      end else begin
        perm_fault = !(pte_eff[`PTE_U_BIT] && pte_eff[`PTE_R_BIT]);
      end
    end
  end

  assign fault_any = walk_fault_q || perm_fault;
  assign ppn       = pte_q[31:`SV32_PTE_PPN_SHIFT];  // 22-bit PPN.

  // Control state.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= mmu_pkg::XLATE_IDLE;
      ready      <= 1'b0;
      page_fault <= 1'b0;
    end else begin
      state      <= state_next;
      ready      <= (start && bypass) || (state == mmu_pkg::XLATE_CHECK);
      page_fault <= (state == mmu_pkg::XLATE_CHECK) && fault_any;
    end
  end

  // Payload registers.
  always_ff @(posedge clk) begin
    if (start && bypass) begin
      physical_address <= {2'b00, address};  // Zero-extended VA.
    end else if (state == mmu_pkg::XLATE_CHECK) begin
      physical_address <= fault_any ? `FAULT_PADDR
                                    : {ppn, address[`SV32_PAGE_SHIFT-1:0]};
    end
    if (walk_valid && walk_ready) begin
      pte_q        <= walk_pte;
      walk_fault_q <= walk_fault;
    end
  end

endmodule

/* logic/sv32_page_walker.sv */
/*
 * Sv32 two-level page table walker.
 *  - Wishbone classic read master, one read per level
 *  - leaf, pointer and invalid PTE decode
 *  - superpage PPN[0] merge and misalignment fault
 */
`timescale 1ns/10ps
`include "mmu_params.svh"

module sv32_page_walker (
  input  logic        clk,
  input  logic        resetn,
  input  logic        walk_valid,
  input  logic [31:0] walk_vaddr,
  input  logic [31:0] walk_satp,
  output logic        walk_ready,  // One-cycle pulse.
  output logic [31:0] walk_pte,    // Leaf PTE for a 4 KiB page.
  output logic        walk_fault,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [33:0] wb_adr,
  input  logic [31:0] wb_dat,
  input  logic        wb_ack
);

  mmu_pkg::walk_state_t state;

  logic        pte_bad;     // V clear or W without R.
  logic        pte_leaf;    // R or X set.
  logic [33:0] l1_adr;
  logic [33:0] l0_adr;
  logic [31:0] leaf_pte;
  logic        leaf_fault;

  assign pte_bad  = !wb_dat[`PTE_V_BIT] || (wb_dat[`PTE_W_BIT] && !wb_dat[`PTE_R_BIT]);
  assign pte_leaf = wb_dat[`PTE_R_BIT] || wb_dat[`PTE_X_BIT];

  // Root table from satp.PPN, indexed by VPN[1].
  assign l1_adr = ({12'h000, walk_satp[21:0]} << `SV32_PAGE_SHIFT)
                | {22'h0, walk_vaddr[31:22], 2'b00};

  // Next table from the level-1 PTE, indexed by VPN[0].
  assign l0_adr = ({12'h000, wb_dat[31:`SV32_PTE_PPN_SHIFT]} << `SV32_PAGE_SHIFT)
                | {22'h0, walk_vaddr[21:12], 2'b00};

  assign walk_ready = (state == mmu_pkg::WALK_DONE);
  assign wb_we      = 1'b0;  // Read only.

  // Result of the PTE on the bus this cycle.
  always_comb begin
    leaf_pte   = wb_dat;
    leaf_fault = pte_bad || !pte_leaf;  // Level 0 must be a leaf.
    if (state == mmu_pkg::WALK_L1) begin
      // Superpage needs PPN[0] clear.
      leaf_fault = pte_bad || (pte_leaf && (wb_dat[`SV32_PTE_PPN_SHIFT +: 10] != 10'h0));
      leaf_pte   = {wb_dat[31:20], walk_vaddr[`SV32_PAGE_SHIFT +: 10], wb_dat[9:0]};
    end
  end

  // FSM and bus strobes.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state  <= mmu_pkg::WALK_IDLE;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else begin
      case (state)
        mmu_pkg::WALK_IDLE: begin
          if (walk_valid) begin
            wb_cyc <= 1'b1;  // Level-1 read.
            wb_stb <= 1'b1;
            state  <= mmu_pkg::WALK_L1;
          end
        end
        mmu_pkg::WALK_L1: begin
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            if (pte_bad || pte_leaf) begin
              state <= mmu_pkg::WALK_DONE;  // Superpage or fault.
            end else begin
              state <= mmu_pkg::WALK_L0;    // Pointer.
            end
          end
        end
        mmu_pkg::WALK_L0: begin
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;  // Level-0 read after one idle cycle.
            wb_stb <= 1'b1;
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            state  <= mmu_pkg::WALK_DONE;
          end
        end
        mmu_pkg::WALK_DONE: state <= mmu_pkg::WALK_IDLE;
        default:            state <= mmu_pkg::WALK_IDLE;
      endcase
    end
  end

  // Address and result registers.
  always_ff @(posedge clk) begin
    if (state == mmu_pkg::WALK_IDLE) begin
      wb_adr <= l1_adr;
    end else if ((state == mmu_pkg::WALK_L1) && wb_ack) begin
      wb_adr <= l0_adr;
    end
    // Level-1 pointer value is overwritten by the level-0 read.
    if (wb_cyc && wb_ack) begin
      walk_pte   <= leaf_pte;
      walk_fault <= leaf_fault;
    end
  end

endmodule

/* logic/sv32_data_mmu.sv */
/*
 * Sv32 data MMU top level.
 *  - translator for the load/store unit
 *  - page walker with its Wishbone master port
 */
`timescale 1ns/10ps

module sv32_data_mmu (
  input  logic                clk,
  input  logic                resetn,
  input  logic [31:0]         address,
  input  logic                is_write,
  input  mmu_pkg::priv_mode_t privilege_mode,
  input  logic [31:0]         satp,
  input  logic [31:0]         mstatus,
  input  logic                valid,
  output logic [33:0]         physical_address,
  output logic                page_fault,
  output logic                ready,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output logic [33:0]         wb_adr,
  input  logic [31:0]         wb_dat,
  input  logic                wb_ack
);

  logic        walk_valid;  // Translator to walker.
  logic [31:0] walk_vaddr;
  logic [31:0] walk_satp;
  logic        walk_ready;  // Walker to translator.
  logic [31:0] walk_pte;
  logic        walk_fault;

  sv32_translate_data u_translate (
    .clk              (clk),
    .resetn           (resetn),
    .address          (address),
    .is_write         (is_write),
    .privilege_mode   (privilege_mode),
    .satp             (satp),
    .mstatus          (mstatus),
    .valid            (valid),
    .physical_address (physical_address),
    .page_fault       (page_fault),
    .ready            (ready),
    .walk_valid       (walk_valid),
    .walk_vaddr       (walk_vaddr),
    .walk_satp        (walk_satp),
    .walk_ready       (walk_ready),
    .walk_pte         (walk_pte),
    .walk_fault       (walk_fault)
  );

  sv32_page_walker u_walker (
    .clk        (clk),
    .resetn     (resetn),
    .walk_valid (walk_valid),
    .walk_vaddr (walk_vaddr),
    .walk_satp  (walk_satp),
    .walk_ready (walk_ready),
    .walk_pte   (walk_pte),
    .walk_fault (walk_fault),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat     (wb_dat),
    .wb_ack     (wb_ack)
  );

endmodule

/* dv/tb_clk_gen.sv */
/*
 * Testbench clock and reset source.
 *  - 10 ns clock
 *  - resetn held low for 4 cycles
 */
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic resetn
);

  initial begin
    clk    = 1'b0;
    resetn = 1'b0;
    repeat (4) @(posedge clk);
    resetn <= 1'b1;  // Released on an edge.
  end

  always #5 clk = ~clk;  // 100 MHz.

endmodule

/* dv/sv32_data_mmu_chk.sv */
/*
 * Protocol assertions for the Sv32 data MMU.
 *  - Wishbone stb/cyc and request stability
 *  - ready pulse width and bypass latency
 */
`timescale 1ns/10ps
`include "mmu_params.svh"

module sv32_data_mmu_chk (
  input logic                clk,
  input logic                resetn,
  input logic                valid,
  input logic                ready,
  input mmu_pkg::priv_mode_t privilege_mode,
  input logic [31:0]         satp,
  input logic [31:0]         mstatus,
  input logic                wb_cyc,
  input logic                wb_stb,
  input logic                wb_ack,
  input logic [33:0]         wb_adr
);

  logic [1:0] eff_priv;
  logic       bypass;

  assign eff_priv = mstatus[`MSTATUS_MPRV_BIT] ? mstatus[`MSTATUS_MPP_LSB +: 2]
                                                : privilege_mode;
  assign bypass   = (eff_priv == 2'd3) || !satp[`SATP_MODE_BIT];

  a_stb_cyc: assert property (@(posedge clk) disable iff (!resetn) wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // Request held until the slave acks.
  a_adr_stable: assert property (@(posedge clk) disable iff (!resetn)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else $error("Wishbone request changed before ack");

  a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn) ready |=> !ready)
    else $error("ready longer than one cycle");

  // New request is first valid cycle, or valid right after a pulse.
  a_bypass_lat: assert property (@(posedge clk) disable iff (!resetn)
    (valid && !ready && (!$past(valid) || $past(ready)) && bypass) |=> ready)
    else $error("bypass ready not one cycle after valid");

endmodule

/* dv/tb_sv32_data_mmu.sv */
/*
 * Testbench for the Sv32 data MMU.
 *  - Wishbone PTE memory model with random ack delay
 *  - reference Sv32 translation from the architectural rules
 *  - directed tests for bypass, MPRV, S/U permissions, superpages
 *  - back-to-back random requests, compare tasks, timeout
 */
`timescale 1ns/10ps
`include "mmu_params.svh"

module tb_sv32_data_mmu;

  localparam int          NUM_REQUESTS = 40;
  localparam int          CYCLE_LIMIT  = NUM_REQUESTS * 20 + 200;
  localparam logic [31:0] SATP_SV32    = 32'h8000_0100;  // Root table at PPN 0x100.
  localparam logic [31:0] MS_SUM       = 32'h1 << `MSTATUS_SUM_BIT;
  localparam logic [31:0] MS_MXR       = 32'h1 << `MSTATUS_MXR_BIT;
  localparam logic [31:0] MS_MPRV      = 32'h1 << `MSTATUS_MPRV_BIT;
  localparam logic [9:0]  F_V = 10'h01;
  localparam logic [9:0]  F_R = 10'h02;
  localparam logic [9:0]  F_W = 10'h04;
  localparam logic [9:0]  F_X = 10'h08;
  localparam logic [9:0]  F_U = 10'h10;

  logic clk;
  logic resetn;
  logic [31:0] address;
  logic is_write;
  mmu_pkg::priv_mode_t privilege_mode;
  logic [31:0] satp;
  logic [31:0] mstatus;
  logic valid;
  logic [33:0] physical_address;
  logic page_fault;
  logic ready;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [33:0] wb_adr;
  logic [31:0] wb_dat;
  logic wb_ack;

  logic [31:0] mem [logic [33:0]];  // PTE memory, absent means zero.
  integer seed = 32'h9126df55;
  int paddr_errors = 0;
  int fault_errors = 0;
  int protocol_errors = 0;
  int cycles = 0;
  logic       ack_pending;
  logic [1:0] ack_wait;
  logic [31:0] vas [6] = '{32'h0040_2000, 32'h0040_3000, 32'h0040_4000,
                           32'h0040_5000, 32'h0040_6000, 32'h0412_3000};

  tb_clk_gen u_clk (.clk(clk), .resetn(resetn));

  sv32_data_mmu u_dut (
    .clk(clk), .resetn(resetn), .address(address), .is_write(is_write),
    .privilege_mode(privilege_mode), .satp(satp), .mstatus(mstatus), .valid(valid),
    .physical_address(physical_address), .page_fault(page_fault), .ready(ready),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat(wb_dat), .wb_ack(wb_ack)
  );

  bind sv32_data_mmu sv32_data_mmu_chk u_chk (
    .clk(clk), .resetn(resetn), .valid(valid), .ready(ready),
    .privilege_mode(privilege_mode), .satp(satp), .mstatus(mstatus),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack), .wb_adr(wb_adr)
  );

  function automatic logic [31:0] mem_read(input logic [33:0] a);
    return mem.exists(a) ? mem[a] : 32'h0;
  endfunction

  // Slave acks 1 to 3 cycles after it sees the strobe.
  always @(posedge clk) begin
    if (!resetn) begin
      wb_ack      <= 1'b0;
      ack_pending <= 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!ack_pending) begin
        ack_pending <= 1'b1;
        ack_wait    <= 2'($unsigned($random(seed)) % 3);
      end else if (ack_wait == 2'd0) begin
        wb_ack      <= 1'b1;
        wb_dat      <= mem_read(wb_adr);
        ack_pending <= 1'b0;
      end else begin
        ack_wait <= ack_wait - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [33:0] l1_addr(input logic [31:0] va);
    return ({12'h0, SATP_SV32[21:0]} << 12) + {va[31:22], 2'b00};
  endfunction

  // Second-level table per VPN[1] at PPN 0x200 + VPN[1].
  task automatic map_4k(input logic [31:0] va, input logic [21:0] ppn, input logic [9:0] fl);
    logic [21:0] tbl;
    tbl = 22'h200 + va[31:22];
    mem[l1_addr(va)] = {tbl, F_V};
    mem[({12'h0, tbl} << 12) + {va[21:12], 2'b00}] = {ppn, fl};
  endtask

  // Expected result from the Sv32 rules; returns the fault bit.
  function automatic logic ref_xlate(input logic [31:0] va, input logic wr,
                                     input mmu_pkg::priv_mode_t pm, input logic [31:0] sp,
                                     input logic [31:0] ms, output logic [33:0] pa,
                                     output logic byp);
    logic [1:0]  eff;
    logic [31:0] pte;
    logic [21:0] ppn;
    logic        flt;
    logic        rd;
    eff = ms[`MSTATUS_MPRV_BIT] ? ms[`MSTATUS_MPP_LSB +: 2] : pm;
    byp = (eff == 2'd3) || !sp[`SATP_MODE_BIT];
    pa  = {2'b00, va};
    flt = 1'b0;
    if (!byp) begin
      pte = mem_read(({12'h0, sp[21:0]} << 12) + {va[31:22], 2'b00});
      ppn = {pte[31:20], va[21:12]};  // Superpage merge.
      if (!pte[`PTE_V_BIT] || (pte[`PTE_W_BIT] && !pte[`PTE_R_BIT])) begin
        flt = 1'b1;
      end else if (pte[`PTE_R_BIT] || pte[`PTE_X_BIT]) begin
        flt = (pte[19:10] != 10'h0);  // Misaligned superpage.
      end else begin
        pte = mem_read(({12'h0, pte[31:10]} << 12) + {va[21:12], 2'b00});
        ppn = pte[31:10];
        flt = !pte[`PTE_V_BIT] || (pte[`PTE_W_BIT] && !pte[`PTE_R_BIT])
           || !(pte[`PTE_R_BIT] || pte[`PTE_X_BIT]);
      end
      rd = pte[`PTE_R_BIT] || (ms[`MSTATUS_MXR_BIT] && pte[`PTE_X_BIT]);
      if (!flt) begin
        if (eff == 2'd1) begin
          flt = (pte[`PTE_U_BIT] && !ms[`MSTATUS_SUM_BIT]) || (wr ? !pte[`PTE_W_BIT] : !rd);
        end else begin
          flt = !pte[`PTE_U_BIT] || (wr ? !pte[`PTE_W_BIT] : !rd);
        end
      end
      pa = flt ? `FAULT_PADDR : {ppn, va[11:0]};
    end
    return flt;
  endfunction

  task automatic check_paddr(input logic [33:0] got, input logic [33:0] exp, input string what);
    if (got !== exp) begin
      paddr_errors++;
      $display("[FAIL] %0t %s: paddr %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_fault(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fault_errors++;
      $display("[FAIL] %0t %s: page_fault %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Drives one request, leaves valid high for a back-to-back follower.
  task automatic run_case(input logic [31:0] va, input logic wr, input mmu_pkg::priv_mode_t pm,
                          input logic [31:0] sp, input logic [31:0] ms, input string what);
    logic [33:0] exp_pa;
    logic        exp_f;
    logic        byp;
    logic        saw_cyc;
    logic        saw_we;
    int          edges;
    exp_f = ref_xlate(va, wr, pm, sp, ms, exp_pa, byp);
    @(posedge clk);
    valid          <= 1'b1;
    address        <= va;
    is_write       <= wr;
    privilege_mode <= pm;
    satp           <= sp;
    mstatus        <= ms;
    edges   = 0;
    saw_cyc = 1'b0;
    saw_we  = 1'b0;
    do begin
      @(negedge clk);
      edges++;
      saw_cyc |= wb_cyc;
      saw_we  |= (wb_we !== 1'b0);
    end while (!ready);
    check_paddr(physical_address, exp_pa, what);
    check_fault(page_fault, exp_f, what);
    // Valid sampled on one edge, ready set on the next.
    if (byp && (edges != 2 || saw_cyc)) begin
      protocol_errors++;
      $display("Bypass request %s took %0d edges or used the Wishbone bus", what, edges);
    end
    if (saw_we) begin
      protocol_errors++;
      $display("Wishbone write enable was not held low during %s", what);
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    valid <= 1'b0;
  endtask

  task automatic test_bypass();
    run_case(32'h1234_5678, 1'b0, mmu_pkg::PRIV_MACHINE, SATP_SV32, 32'h0, "machine bypass");
    go_idle();
    run_case(32'h8765_4321, 1'b1, mmu_pkg::PRIV_SUPERVISOR, 32'h0, 32'h0, "bare S");
    go_idle();
    run_case(32'hfeed_0ffc, 1'b0, mmu_pkg::PRIV_USER, 32'h0, 32'h0, "bare U");
    go_idle();
  endtask

  task automatic test_mprv();
    run_case(32'h0040_3abc, 1'b1, mmu_pkg::PRIV_MACHINE, SATP_SV32,
             MS_MPRV | (32'd1 << `MSTATUS_MPP_LSB), "MPRV MPP=S");
    go_idle();
    run_case(32'h0040_3abc, 1'b1, mmu_pkg::PRIV_MACHINE, SATP_SV32,
             MS_MPRV | (32'd3 << `MSTATUS_MPP_LSB), "MPRV MPP=M");
    go_idle();
    run_case(32'h0040_3abc, 1'b0, mmu_pkg::PRIV_MACHINE, SATP_SV32, MS_MPRV, "MPRV MPP=U");
    go_idle();
  endtask

  task automatic test_supervisor();
    run_case(32'h0040_2010, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "S read R");
    run_case(32'h0040_2010, 1'b1, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "S write R");
    run_case(32'h0040_3020, 1'b1, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "S write RW");
    run_case(32'h0040_4030, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "S U no SUM");
    run_case(32'h0040_4030, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, MS_SUM, "S U SUM");
    run_case(32'h0040_5040, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "S X no MXR");
    run_case(32'h0040_5040, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, MS_MXR, "S X MXR");
    go_idle();
  endtask

  task automatic test_user();
    run_case(32'h0040_3100, 1'b0, mmu_pkg::PRIV_USER, SATP_SV32, 32'h0, "U non-U page");
    run_case(32'h0040_4200, 1'b0, mmu_pkg::PRIV_USER, SATP_SV32, 32'h0, "U read URW");
    run_case(32'h0040_4200, 1'b1, mmu_pkg::PRIV_USER, SATP_SV32, 32'h0, "U write URW");
    run_case(32'h0040_6300, 1'b1, mmu_pkg::PRIV_USER, SATP_SV32, 32'h0, "U write UR");
    run_case(32'h0040_6300, 1'b0, mmu_pkg::PRIV_USER, SATP_SV32, 32'h0, "U read UR");
    go_idle();
  endtask

  task automatic test_superpage();
    run_case(32'h0412_3456, 1'b1, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "superpage");
    run_case(32'h0452_3456, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "misaligned");
    run_case(32'h0480_0000, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "L1 V clear");
    run_case(32'h04c0_0000, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "L1 W no R");
    run_case(32'h0040_7000, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "L0 W no R");
    run_case(32'h0040_8000, 1'b0, mmu_pkg::PRIV_SUPERVISOR, SATP_SV32, 32'h0, "L0 pointer");
    go_idle();
  endtask

  task automatic test_back_to_back();
    logic [31:0] va;
    int          r;
    mmu_pkg::priv_mode_t pm;
    for (int i = 0; i < 16; i++) begin
      r  = $random(seed);
      va = vas[$unsigned(r) % 6] | (r[27:16] & 32'hfff);
      pm = r[4] ? mmu_pkg::PRIV_USER : mmu_pkg::PRIV_SUPERVISOR;
      run_case(va, r[5], pm, SATP_SV32, {12'h0, r[7:6], 18'h0}, "back-to-back");
    end
    go_idle();
  endtask

  initial begin
    valid          = 1'b0;
    address        = 32'h0;
    is_write       = 1'b0;
    privilege_mode = mmu_pkg::PRIV_MACHINE;
    satp           = 32'h0;
    mstatus        = 32'h0;
    wb_dat         = 32'h0;
    wb_ack         = 1'b0;
    map_4k(32'h0040_2000, 22'h0_1002, F_V | F_R);
    map_4k(32'h0040_3000, 22'h0_1003, F_V | F_R | F_W);
    map_4k(32'h0040_4000, 22'h0_1004, F_V | F_R | F_W | F_U);
    map_4k(32'h0040_5000, 22'h0_1005, F_V | F_X);
    map_4k(32'h0040_6000, 22'h0_1006, F_V | F_R | F_U);
    map_4k(32'h0040_7000, 22'h0_1007, F_V | F_W);
    map_4k(32'h0040_8000, 22'h0_1008, F_V);  // Pointer at level 0.
    mem[l1_addr(32'h0412_3000)] = {12'habc, 10'h000, F_V | F_R | F_W};
    mem[l1_addr(32'h0452_3000)] = {12'habd, 10'h001, F_V | F_R};
    mem[l1_addr(32'h0480_0000)] = {12'habe, 10'h000, F_R | F_W};
    mem[l1_addr(32'h04c0_0000)] = {12'habf, 10'h000, F_V | F_W};
    wait (resetn);
    test_bypass();
    test_mprv();
    test_supervisor();
    test_user();
    test_superpage();
    test_back_to_back();
    repeat (4) @(posedge clk);
    $display("Errors: paddr %0d, fault %0d, protocol %0d",
             paddr_errors, fault_errors, protocol_errors);
    if (paddr_errors + fault_errors + protocol_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+logic
logic/mmu_pkg.sv
logic/sv32_translate_data.sv
logic/sv32_page_walker.sv
logic/sv32_data_mmu.sv
dv/tb_clk_gen.sv
dv/sv32_data_mmu_chk.sv
dv/tb_sv32_data_mmu.sv

/* Makefile */
# Verilator build and run for the Sv32 data MMU testbench.

VERILATOR ?= verilator
TOP       ?= tb_sv32_data_mmu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "No result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
